// File: Bender.yml
package:
  name: match_engine

export_include_dirs:
  - .

sources:
  - match_engine_pkg.sv
  - hash_batch_dispatch.sv
  - job_match_pe.sv
  - seq_packet_merge.sv
  - match_engine.sv
  - target: test
    files:
      - tb_match_engine.sv

// File: hash_batch_dispatch.sv
`default_nettype none
`timescale 1ns/1ns

`include "match_engine_defs.svh"

module hash_batch_dispatch (
    input  wire                            clk,
    input  wire                            rst_n,

    input  logic                           i_batch_valid,
    input  match_engine_pkg::hash_batch_t  i_batch,
    output logic                           o_batch_ready,

    output logic [`NUM_JOB_PE-1:0]         o_pe_valid,
    output match_engine_pkg::hash_batch_t  o_pe_batch,
    input  logic [`NUM_JOB_PE-1:0]         i_pe_ready
);

    // which PE gets the next batch
    logic turn_q;
    logic xfer;

    // only the PE on turn sees valid
    assign o_pe_valid[0] = i_batch_valid & ~turn_q;
    assign o_pe_valid[1] = i_batch_valid & turn_q;

    // a busy PE on turn stalls the input, the other one waits its turn
    assign o_batch_ready = i_pe_ready[turn_q];

    // payload is shared, valid selects the target
    assign o_pe_batch = i_batch;

    assign xfer = i_batch_valid & o_batch_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            turn_q <= 1'b0;
        end else if (xfer) begin
            turn_q <= ~turn_q;
        end
    end

endmodule

`default_nettype wire

// File: job_match_pe.sv
`default_nettype none
`timescale 1ns/1ns

`include "match_engine_defs.svh"

module job_match_pe (
    input  wire                            clk,
    input  wire                            rst_n,

    input  match_engine_pkg::hist_write_t  i_hist_write,

    input  logic                           i_batch_valid,
    input  match_engine_pkg::hash_batch_t  i_batch,
    output logic                           o_batch_ready,

    output logic                           o_seq_valid,
    output match_engine_pkg::seq_t         o_seq,
    input  logic                           i_seq_ready
);

    import match_engine_pkg::*;

    localparam int BYTE_SEL_W = $clog2(`MATCH_PE_WIDTH);
    localparam int STEP_W     = $clog2(`MAX_MATCH_LEN);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_SELECT,
        ST_DONE
    } state_t;

    state_t state_q;

    // local copy of the history window
    logic [7:0] hist [`HIST_BYTES];

    hash_batch_t                     batch_q;
    logic [STEP_W-1:0]               step_q;
    logic [`HASH_ISSUE_WIDTH-1:0]    match_q;
    logic [`ML_WIDTH-1:0]            len_q [`HASH_ISSUE_WIDTH];

    logic [`ADDR_WIDTH-1:0]          head_ptr;
    logic [`ADDR_WIDTH-1:0]          cand_ptr [`HASH_ISSUE_WIDTH];

    logic                            best_found;
    logic [`ML_WIDTH-1:0]            best_len;
    logic [`ADDR_WIDTH-1:0]          best_addr;

    // every write lands in all PE copies at once
    always_ff @(posedge clk) begin
        if (i_hist_write.enable) begin
            for (int b = 0; b < `MATCH_PE_WIDTH; b++) begin
                hist[{i_hist_write.addr, BYTE_SEL_W'(b)}] <= i_hist_write.data[b];
            end
        end
    end

    // byte pointers wrap at the window size
    always_comb begin
        head_ptr = batch_q.head_addr + `ADDR_WIDTH'(step_q);
        for (int i = 0; i < `HASH_ISSUE_WIDTH; i++) begin
            cand_ptr[i] = batch_q.history_addr[i] + `ADDR_WIDTH'(step_q);
        end
    end

    // longest valid candidate, strict compare keeps the lowest index on ties
    always_comb begin
        best_found = 1'b0;
        best_len   = '0;
        best_addr  = '0;
        for (int i = 0; i < `HASH_ISSUE_WIDTH; i++) begin
            if (batch_q.history_valid[i] && (!best_found || len_q[i] > best_len)) begin
                best_found = 1'b1;
                best_len   = len_q[i];
                best_addr  = batch_q.history_addr[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            step_q  <= '0;
            match_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (i_batch_valid) begin
                        state_q <= ST_COMPARE;
                        step_q  <= '0;
                        match_q <= i_batch.history_valid;
                    end
                end
                ST_COMPARE: begin
                    for (int i = 0; i < `HASH_ISSUE_WIDTH; i++) begin
                        if (match_q[i] && hist[cand_ptr[i]] != hist[head_ptr]) begin
                            match_q[i] <= 1'b0;
                        end
                    end
                    step_q <= step_q + 1'b1;
                    if (step_q == STEP_W'(`MAX_MATCH_LEN - 1)) begin
                        state_q <= ST_SELECT;
                    end
                end
                ST_SELECT: begin
                    state_q <= ST_DONE;
                end
                ST_DONE: begin
                    if (i_seq_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // batch, lengths and result
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && i_batch_valid) begin
            batch_q <= i_batch;
            for (int i = 0; i < `HASH_ISSUE_WIDTH; i++) begin
                len_q[i] <= '0;
            end
        end
        if (state_q == ST_COMPARE) begin
            for (int i = 0; i < `HASH_ISSUE_WIDTH; i++) begin
                if (match_q[i] && hist[cand_ptr[i]] == hist[head_ptr]) begin
                    len_q[i] <= len_q[i] + 1'b1;
                end
            end
        end
        if (state_q == ST_SELECT) begin
            o_seq.ml     <= best_len;
            o_seq.offset <= best_found ? batch_q.head_addr - best_addr : '0;
            o_seq.delim  <= batch_q.delim;
        end
    end

    assign o_batch_ready = (state_q == ST_IDLE);
    assign o_seq_valid   = (state_q == ST_DONE);

endmodule

`default_nettype wire

// File: match_engine.f
+incdir+.
match_engine_pkg.sv
hash_batch_dispatch.sv
job_match_pe.sv
seq_packet_merge.sv
match_engine.sv
tb_match_engine.sv

// File: match_engine.sv
`default_nettype none
`timescale 1ns/1ns

`include "match_engine_defs.svh"

module match_engine (
    input  wire                            clk,
    input  wire                            rst_n,

    input  logic                           i_hash_batch_valid,
    input  match_engine_pkg::hash_batch_t  i_hash_batch,
    output logic                           o_hash_batch_ready,

    output logic                           o_seq_valid,
    output match_engine_pkg::seq_t         o_seq,
    input  logic                           i_seq_ready,

    input  match_engine_pkg::hist_write_t  i_hist_write
);

    import match_engine_pkg::*;

    logic [`NUM_JOB_PE-1:0]         dispatch_valid;
    hash_batch_t                    dispatch_batch;
    logic [`NUM_JOB_PE-1:0]         dispatch_ready;

    logic [`NUM_JOB_PE-1:0]         result_valid;
    seq_t [`NUM_JOB_PE-1:0]         result;
    logic [`NUM_JOB_PE-1:0]         result_ready;

    hash_batch_dispatch u_dispatch (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_batch_valid  (i_hash_batch_valid),
        .i_batch        (i_hash_batch),
        .o_batch_ready  (o_hash_batch_ready),
        .o_pe_valid     (dispatch_valid),
        .o_pe_batch     (dispatch_batch),
        .i_pe_ready     (dispatch_ready)
    );

    // write port goes to both window copies
    job_match_pe u_pe0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_hist_write   (i_hist_write),
        .i_batch_valid  (dispatch_valid[0]),
        .i_batch        (dispatch_batch),
        .o_batch_ready  (dispatch_ready[0]),
        .o_seq_valid    (result_valid[0]),
        .o_seq          (result[0]),
        .i_seq_ready    (result_ready[0])
    );

    job_match_pe u_pe1 (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_hist_write   (i_hist_write),
        .i_batch_valid  (dispatch_valid[1]),
        .i_batch        (dispatch_batch),
        .o_batch_ready  (dispatch_ready[1]),
        .o_seq_valid    (result_valid[1]),
        .o_seq          (result[1]),
        .i_seq_ready    (result_ready[1])
    );

    seq_packet_merge u_merge (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_pe_valid     (result_valid),
        .i_pe_seq       (result),
        .o_pe_ready     (result_ready),
        .o_seq_valid    (o_seq_valid),
        .o_seq          (o_seq),
        .i_seq_ready    (i_seq_ready)
    );

endmodule

`default_nettype wire

// File: match_engine_defs.svh
`ifndef MATCH_ENGINE_DEFS_SVH
`define MATCH_ENGINE_DEFS_SVH

// byte address into the history window
`define ADDR_WIDTH 8

// history window size in bytes, one copy per job PE
`define HIST_BYTES 256

// bytes carried by one write on the history write port
`define MATCH_PE_WIDTH 4

// candidates per hash batch
`define HASH_ISSUE_WIDTH 4

// longest match measured
`define MAX_MATCH_LEN 16
`define ML_WIDTH 5

// dispatcher and merger are built for exactly two PEs
`define NUM_JOB_PE 2

`endif

// File: match_engine_pkg.sv
`default_nettype none

`include "match_engine_defs.svh"

package match_engine_pkg;

    // one hash batch from the hash stage
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0]                          head_addr;
        logic [`HASH_ISSUE_WIDTH-1:0]                    history_valid;
        logic [`HASH_ISSUE_WIDTH-1:0][`ADDR_WIDTH-1:0]   history_addr;
        logic                                            delim;
    } hash_batch_t;

    // one sequence, single sequence per packet
    typedef struct packed {
        logic [`ML_WIDTH-1:0]   ml;
        logic [`ADDR_WIDTH-1:0] offset;
        logic                   delim;
    } seq_t;

    // history write port, word addressed
    typedef struct packed {
        logic [`ADDR_WIDTH-$clog2(`MATCH_PE_WIDTH)-1:0] addr;
        logic [`MATCH_PE_WIDTH-1:0][7:0]                data;
        logic                                           enable;
    } hist_write_t;

endpackage

`default_nettype wire

// File: seq_packet_merge.sv
`default_nettype none
`timescale 1ns/1ns

`include "match_engine_defs.svh"

module seq_packet_merge (
    input  wire                                          clk,
    input  wire                                          rst_n,

    input  logic [`NUM_JOB_PE-1:0]                       i_pe_valid,
    input  match_engine_pkg::seq_t [`NUM_JOB_PE-1:0]     i_pe_seq,
    output logic [`NUM_JOB_PE-1:0]                       o_pe_ready,

    output logic                                         o_seq_valid,
    output match_engine_pkg::seq_t                       o_seq,
    input  logic                                         i_seq_ready
);

    // follows the dispatcher's alternation, one step per output
    logic turn_q;
    logic xfer;

    // result of the PE on turn goes straight out
    assign o_seq_valid = i_pe_valid[turn_q];
    assign o_seq       = i_pe_seq[turn_q];

    // the other PE holds its result until the turn comes round
    assign o_pe_ready[0] = i_seq_ready & ~turn_q;
    assign o_pe_ready[1] = i_seq_ready & turn_q;

    assign xfer = o_seq_valid & i_seq_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            turn_q <= 1'b0;
        end else if (xfer) begin
            turn_q <= ~turn_q;
        end
    end

endmodule

`default_nettype wire

// File: tb_match_engine.sv
`default_nettype none
`timescale 1ns/1ns

`include "match_engine_defs.svh"

module tb_match_engine;

    import match_engine_pkg::*;

    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 20000;
    localparam int LAT_TIMEOUT    = 100;
    localparam int NUM_RANDOM     = 200;
    localparam int BP_LEN         = 4096;

    logic        clk;
    logic        rst_n;
    logic        i_hash_batch_valid;
    hash_batch_t i_hash_batch;
    logic        o_hash_batch_ready;
    logic        o_seq_valid;
    seq_t        o_seq;
    logic        i_seq_ready;
    hist_write_t i_hist_write;

    logic [7:0]  model_hist [`HIST_BYTES];
    seq_t        exp_q [$];
    bit          bp_pattern [BP_LEN];
    bit          bp_mode;
    int          bp_idx;
    int          errors;
    int          timeouts;
    int          in_count;
    int          out_count;
    bit          hold_pending;
    seq_t        held_seq;

    match_engine i_match_engine (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_hash_batch_valid (i_hash_batch_valid),
        .i_hash_batch       (i_hash_batch),
        .o_hash_batch_ready (o_hash_batch_ready),
        .o_seq_valid        (o_seq_valid),
        .o_seq              (o_seq),
        .i_seq_ready        (i_seq_ready),
        .i_hist_write       (i_hist_write)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t %s: got 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            errors++;
        end
    endtask

    // model of the PE rule, prefix match per candidate
    function automatic seq_t predict_seq(input hash_batch_t b);
        seq_t s;
        int   best;
        int   best_idx;
        int   len;
        best     = -1;
        best_idx = 0;
        for (int i = 0; i < `HASH_ISSUE_WIDTH; i++) begin
            if (b.history_valid[i]) begin
                len = 0;
                while (len < `MAX_MATCH_LEN &&
                       model_hist[8'(b.head_addr + len)] ==
                       model_hist[8'(b.history_addr[i] + len)]) begin
                    len++;
                end
                if (len > best) begin
                    best     = len;
                    best_idx = i;
                end
            end
        end
        s.ml     = (best < 0) ? '0 : `ML_WIDTH'(best);
        s.offset = (best < 0) ? '0 : 8'(b.head_addr - b.history_addr[best_idx]);
        s.delim  = b.delim;
        return s;
    endfunction

    function automatic hash_batch_t random_batch();
        hash_batch_t b;
        b.head_addr     = 8'($urandom);
        b.history_valid = 4'($urandom);
        // candidates a short distance behind the head
        for (int i = 0; i < `HASH_ISSUE_WIDTH; i++) begin
            b.history_addr[i] = 8'(b.head_addr - 1 - ($urandom % 32));
        end
        b.delim = 1'($urandom);
        return b;
    endfunction

    // copies the whole model window into the DUT, one word per cycle
    task automatic load_window();
        for (int w = 0; w < `HIST_BYTES / `MATCH_PE_WIDTH; w++) begin
            i_hist_write.addr = 6'(w);
            for (int b = 0; b < `MATCH_PE_WIDTH; b++) begin
                i_hist_write.data[b] = model_hist[w * `MATCH_PE_WIDTH + b];
            end
            i_hist_write.enable = 1'b1;
            @(posedge clk);
            #1;
        end
        i_hist_write.enable = 1'b0;
    endtask

    task automatic plant_copy(input int cand, input int head, input int len);
        for (int k = 0; k < len; k++) begin
            model_hist[8'(cand + k)] = model_hist[8'(head + k)];
        end
        model_hist[8'(cand + len)] = model_hist[8'(head + len)] ^ 8'hff;
    endtask

    task automatic send_batch(input hash_batch_t b);
        int waited;
        waited             = 0;
        i_hash_batch_valid = 1'b1;
        i_hash_batch       = b;
        @(negedge clk);
        while (!o_hash_batch_ready && waited < ACCEPT_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!o_hash_batch_ready) begin
            $display("timeout: batch input was never accepted at time %0t", $time);
            timeouts++;
        end else begin
            exp_q.push_back(predict_seq(b));
            in_count++;
        end
        @(posedge clk);
        #1;
        i_hash_batch_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d sequences still missing at time %0t", exp_q.size(), $time);
            timeouts++;
        end
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        #1;
        if (bp_mode) begin
            i_seq_ready = bp_pattern[bp_idx];
            bp_idx      = (bp_idx + 1) % BP_LEN;
        end else begin
            i_seq_ready = 1'b1;
        end
    end

    // output monitor, samples mid-cycle what transfers on the next edge
    always @(negedge clk) begin
        seq_t exp;
        if (rst_n) begin
            if (hold_pending) begin
                if (!o_seq_valid) begin
                    $display("o_seq_valid dropped before its transfer at time %0t", $time);
                    errors++;
                end else begin
                    check_value("o_seq (held)", o_seq, held_seq);
                end
            end
            hold_pending = 1'b0;
            if (o_seq_valid && i_seq_ready) begin
                out_count++;
                if (exp_q.size() == 0) begin
                    $display("sequence output at time %0t with no batch pending", $time);
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    check_value("o_seq.ml", o_seq.ml, exp.ml);
                    check_value("o_seq.offset", o_seq.offset, exp.offset);
                    check_value("o_seq.delim", o_seq.delim, exp.delim);
                end
            end else if (o_seq_valid) begin
                hold_pending = 1'b1;
                held_seq     = o_seq;
            end
        end
    end

    initial begin
        hash_batch_t b;
        seq_t        s;
        int          idx;
        int          run;
        int          lat;
        bit          lvl;
        void'($urandom(29));
        rst_n              = 1'b0;
        i_hash_batch_valid = 1'b0;
        i_hash_batch       = '0;
        i_hist_write       = '0;
        i_seq_ready        = 1'b0;
        bp_mode            = 1'b0;
        bp_idx             = 0;
        errors             = 0;
        timeouts           = 0;
        in_count           = 0;
        out_count          = 0;
        hold_pending       = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("o_seq_valid after reset", o_seq_valid, 1'b0);
        check_value("o_hash_batch_ready after reset", o_hash_batch_ready, 1'b1);
        @(posedge clk);
        #1;

        // 8-byte period inside each 32-byte block
        for (int a = 0; a < `HIST_BYTES; a++) begin
            model_hist[a] = {a[7:5], 2'b10, a[2:0]};
        end
        load_window();
        b               = random_batch();
        b.head_addr     = 8'd72;
        b.history_valid = 4'b0100;
        b.history_addr[2] = 8'd64;
        s = predict_seq(b);
        check_value("model ml, periodic window", s.ml, 16);
        check_value("model offset, periodic window", s.offset, 8);
        send_batch(b);
        wait_drain();

        // planted copies of length 5, 11, 11 and 3
        for (int a = 0; a < `HIST_BYTES; a++) begin
            model_hist[a] = 8'($urandom);
        end
        plant_copy(8'h10, 8'hc0, 5);
        plant_copy(8'h40, 8'hc0, 11);
        plant_copy(8'h70, 8'hc0, 11);
        plant_copy(8'h90, 8'hc0, 3);
        load_window();
        b.head_addr     = 8'hc0;
        b.history_addr  = {8'h90, 8'h70, 8'h40, 8'h10};
        b.history_valid = 4'b1111;
        b.delim         = 1'b0;
        s = predict_seq(b);
        check_value("model ml, tie", s.ml, 11);
        check_value("model offset, tie", s.offset, 8'h80);
        send_batch(b);
        b.history_valid = 4'b1001;
        send_batch(b);
        b.history_valid = 4'b1100;
        send_batch(b);
        wait_drain();

        b               = random_batch();
        b.history_valid = 4'b0000;
        b.delim         = 1'b1;
        s = predict_seq(b);
        check_value("model ml, no candidate", s.ml, 0);
        check_value("model offset, no candidate", s.offset, 0);
        send_batch(b);
        wait_drain();

        // latency from the accept edge, engine idle
        send_batch(random_batch());
        lat = 0;
        @(negedge clk);
        while (!o_seq_valid && lat < LAT_TIMEOUT) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        if (!o_seq_valid) begin
            $display("timeout: no sequence output after a single batch");
            timeouts++;
        end
        check_value("accept to o_seq_valid cycles", lat, `MAX_MATCH_LEN + 1);
        wait_drain();

        // two-symbol window gives a spread of match lengths
        for (int a = 0; a < `HIST_BYTES; a++) begin
            model_hist[a] = 8'($urandom % 2);
        end
        load_window();
        repeat (NUM_RANDOM) send_batch(random_batch());
        wait_drain();

        idx = 0;
        while (idx < BP_LEN) begin
            lvl = 1'($urandom);
            run = 1 + ($urandom % 24);
            repeat (run) begin
                if (idx < BP_LEN) begin
                    bp_pattern[idx] = lvl;
                end
                idx++;
            end
        end
        bp_mode = 1'b1;
        repeat (NUM_RANDOM) send_batch(random_batch());
        wait_drain();
        bp_mode = 1'b0;
        repeat (4) @(posedge clk);
        check_value("output count", out_count, in_count);

        $display("summary: %0d batches in, %0d sequences out, %0d errors, %0d timeouts",
                 in_count, out_count, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
